// File: logic/lerp_pipeline.sv
// linear interpolator, chains one subdivision stage per rate bit

`timescale 1ns/1ps
`default_nettype none

`include "upsampler_config.svh"

module lerp_pipeline
	import upsampler_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       cke,
	input  lerp_req_t  req,
	input  logic       req_valid,
	output out_point_t point,
	output logic       point_valid
);

	localparam int STAGES = `UPS_RATE_BITS;

	// entry 0 is the request, entry i is the output of stage i-1
	lerp_req_t              stage_req [STAGES+1];
	logic      [STAGES:0]   stage_valid;

	assign stage_req[0]   = req;
	assign stage_valid[0] = req_valid;

	// ----------------------------------------------------------------------
	// subdivision chain
	// ----------------------------------------------------------------------

	for (genvar i = 0; i < STAGES; i++) begin : g_stage
		lerp_stage u_stage (
			.clk     (clk),
			.reset   (reset),
			.cke     (cke),
			.s_req   (stage_req[i]),
			.s_valid (stage_valid[i]),
			.m_req   (stage_req[i+1]),
			.m_valid (stage_valid[i+1])
		);
	end

	// ----------------------------------------------------------------------
	// output
	// ----------------------------------------------------------------------

	// interval has shrunk to one point, data0 holds it
	// guard bit is no longer needed, value is back in sample range
	assign point.first  = stage_req[STAGES].first;
	assign point.sample = stage_req[STAGES].data0[`UPS_SAMPLE_WIDTH-1:0];
	assign point_valid  = stage_valid[STAGES];

endmodule

`default_nettype wire

// File: logic/lerp_stage.sv
// interpolator stage, keeps one half of the interval picked by the top rate bit

`timescale 1ns/1ps
`default_nettype none

`include "upsampler_config.svh"

module lerp_stage
	import upsampler_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      cke,
	input  lerp_req_t s_req,
	input  logic      s_valid,
	output lerp_req_t m_req,
	output logic      m_valid
);

	wide_sample_t d0;
	wide_sample_t d1;
	wide_sample_t mid;
	logic         upper;

	// midpoint, arithmetic shift rounds toward minus infinity
	always_comb begin
		d0    = s_req.data0;
		d1    = s_req.data1;
		mid   = (d0 + d1) >>> 1;
		upper = s_req.rate[`UPS_RATE_BITS-1];
	end

	// ----------------------------------------------------------------------
	// data path
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (cke) begin
			m_req.first <= s_req.first;
			m_req.rate  <= s_req.rate << 1;
			// lower half keeps data0, upper half keeps data1
			m_req.data0 <= upper ? mid : d0;
			m_req.data1 <= upper ? d1 : mid;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			m_valid <= 1'b0;
		end else if (cke) begin
			m_valid <= s_valid;
		end
	end

endmodule

`default_nettype wire

// File: logic/phase_gen.sv
// phase generator, issues one interpolation request per phase of each segment

`timescale 1ns/1ps
`default_nettype none

`include "upsampler_config.svh"

module phase_gen
	import upsampler_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      cke,
	input  logic      in_valid,
	input  sample_t   in_sample,
	output logic      busy,
	output lerp_req_t req,
	output logic      req_valid
);

	typedef enum logic {
		ST_IDLE,
		ST_ISSUE
	} state_t;

	state_t  state;
	rate_t   phase;
	sample_t prev_sample;
	sample_t cur_sample;

	// ----------------------------------------------------------------------
	// control
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= ST_IDLE;
			phase       <= '0;
			prev_sample <= '0;
			req_valid   <= 1'b0;
		end else if (cke) begin
			case (state)
				ST_IDLE: begin
					req_valid <= 1'b0;
					if (in_valid) begin
						state <= ST_ISSUE;
						phase <= '0;
					end
				end
				ST_ISSUE: begin
					req_valid <= 1'b1;
					phase     <= phase + 1'b1;
					// segment done, new sample becomes the start point
					if (phase == '1) begin
						state       <= ST_IDLE;
						prev_sample <= cur_sample;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// payload
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (cke) begin
			if (state == ST_IDLE && in_valid) begin
				cur_sample <= in_sample;
			end
			if (state == ST_ISSUE) begin
				req.first <= (phase == '0);
				req.rate  <= phase;
				// sign extend into the guard bit
				req.data0 <= {prev_sample[`UPS_SAMPLE_WIDTH-1], prev_sample};
				req.data1 <= {cur_sample[`UPS_SAMPLE_WIDTH-1], cur_sample};
			end
		end
	end

	// frozen pipeline cannot take a new segment either
	assign busy = (state == ST_ISSUE) || !cke;

endmodule

`default_nettype wire

// File: logic/sample_fifo.sv
// output FIFO of interpolated points with a registered occupancy count

`timescale 1ns/1ps
`default_nettype none

`include "upsampler_config.svh"

module sample_fifo
	import upsampler_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        wr_en,
	input  out_point_t  wr_point,
	input  logic        pop,
	output out_point_t  rd_point,
	output logic        valid,
	output fifo_count_t count
);

	localparam int DEPTH = `UPS_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	typedef logic [PTR_W-1:0] ptr_t;

	out_point_t mem [DEPTH];
	ptr_t       wr_ptr;
	ptr_t       rd_ptr;
	logic       do_pop;

	// wrap explicitly so depth need not be a power of two
	function automatic ptr_t next_ptr(input ptr_t ptr);
		if (ptr == ptr_t'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// a pop on an empty buffer is dropped
	assign do_pop = pop && valid;

	// ----------------------------------------------------------------------
	// storage
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_point;
		end
	end

	assign rd_point = mem[rd_ptr];

	// ----------------------------------------------------------------------
	// pointers and count
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// push and pop together leave the count alone
			case ({wr_en, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign valid = (count != '0);

endmodule

`default_nettype wire

// File: logic/upsampler_config.svh
// upsampler configuration, sample width, phase bits and output FIFO depth

`ifndef UPSAMPLER_CONFIG_SVH
`define UPSAMPLER_CONFIG_SVH

// ----------------------------------------------------------------------
// sample format
// ----------------------------------------------------------------------

// two's complement input and output samples
`define UPS_SAMPLE_WIDTH 8

// ----------------------------------------------------------------------
// interpolation
// ----------------------------------------------------------------------

// 2^rate_bits points per segment, one pipeline stage per bit
`define UPS_RATE_BITS 4

// ----------------------------------------------------------------------
// output buffering
// ----------------------------------------------------------------------

// must exceed UPS_RATE_BITS + 1 so in-flight points always fit
`define UPS_FIFO_DEPTH 16

`endif

// File: logic/upsampler_pkg.sv
// upsampler shared types for samples, phases, requests and output points

`default_nettype none

`include "upsampler_config.svh"

package upsampler_pkg;

	typedef logic signed [`UPS_SAMPLE_WIDTH-1:0] sample_t;

	// one guard bit so the sum of two ends cannot overflow
	typedef logic signed [`UPS_SAMPLE_WIDTH:0] wide_sample_t;

	// phase within a segment, read as a fraction
	typedef logic [`UPS_RATE_BITS-1:0] rate_t;

	// fifo occupancy, 0 .. depth inclusive
	typedef logic [$clog2(`UPS_FIFO_DEPTH+1)-1:0] fifo_count_t;

	typedef struct packed {
		logic         first;
		rate_t        rate;
		wide_sample_t data0;
		wide_sample_t data1;
	} lerp_req_t;

	typedef struct packed {
		logic    first;
		sample_t sample;
	} out_point_t;

endpackage

`default_nettype wire

// File: logic/upsampler_top.sv
// streaming upsampler, phase generator into interpolator into output FIFO

`timescale 1ns/1ps
`default_nettype none

`include "upsampler_config.svh"

module upsampler_top
	import upsampler_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       in_valid,
	input  sample_t    in_sample,
	output logic       in_busy,
	output logic       out_valid,
	output out_point_t out_point,
	input  logic       out_pop
);

	// room must stay for every point still in the pipeline
	localparam fifo_count_t CKE_LIMIT =
		fifo_count_t'(`UPS_FIFO_DEPTH - `UPS_RATE_BITS - 1);

	logic        cke;
	lerp_req_t   req;
	logic        req_valid;
	out_point_t  point;
	logic        point_valid;
	fifo_count_t fifo_count;

	// ----------------------------------------------------------------------
	// flow control
	// ----------------------------------------------------------------------

	assign cke = (fifo_count <= CKE_LIMIT);

	// ----------------------------------------------------------------------
	// blocks
	// ----------------------------------------------------------------------

	phase_gen u_phase_gen (
		.clk       (clk),
		.reset     (reset),
		.cke       (cke),
		.in_valid  (in_valid),
		.in_sample (in_sample),
		.busy      (in_busy),
		.req       (req),
		.req_valid (req_valid)
	);

	lerp_pipeline u_lerp_pipeline (
		.clk         (clk),
		.reset       (reset),
		.cke         (cke),
		.req         (req),
		.req_valid   (req_valid),
		.point       (point),
		.point_valid (point_valid)
	);

	// held output is only written once, on the edge the pipeline advances
	sample_fifo u_sample_fifo (
		.clk      (clk),
		.reset    (reset),
		.wr_en    (point_valid && cke),
		.wr_point (point),
		.pop      (out_pop),
		.rd_point (out_point),
		.valid    (out_valid),
		.count    (fifo_count)
	);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# builds the upsampler testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -Wno-fatal -f sim.f --top-module upsampler_tb \
	-o upsampler_sim > "$LOG" 2>&1 \
	&& ./obj_dir/upsampler_sim >> "$LOG" 2>&1 \
	|| { echo "build or run error, see $LOG"; exit 1; }

grep -q "^Regression passed$" "$LOG" && echo "PASS" \
	|| { echo "FAIL, see $LOG"; exit 1; }

// File: sim.f
+incdir+logic
logic/upsampler_pkg.sv
logic/phase_gen.sv
logic/lerp_stage.sv
logic/lerp_pipeline.sv
logic/sample_fifo.sv
logic/upsampler_top.sv
sim/upsampler_tb.sv

// File: sim/upsampler_tb.sv
// testbench for the upsampler with random samples and pops checked against a bisection model

`timescale 1ns/1ps
`default_nettype none

`include "upsampler_config.svh"

module upsampler_tb
	import upsampler_pkg::*;
();

	localparam int SEG_POINTS = 1 << `UPS_RATE_BITS;
	localparam int WAIT_LIMIT = 2000;
	localparam int NUM_RANDOM = 40;
	localparam int POP_NONE   = 0;
	localparam int POP_ALWAYS = 1;
	localparam int POP_RANDOM = 2;

	logic       clk;
	logic       reset;
	logic       in_valid;
	sample_t    in_sample;
	logic       in_busy;
	logic       out_valid;
	out_point_t out_point;
	logic       out_pop;

	// separate generator states for samples and pops
	logic [31:0] stim_state = 32'hfd3e;
	logic [31:0] pop_state  = 32'hfd3e;
	int          pop_mode   = POP_NONE;
	sample_t     prev_model = '0;
	out_point_t  exp_q [$];
	int          errors     = 0;
	int          checks     = 0;
	int          accepted   = 0;
	int          popped     = 0;

	upsampler_top UUT (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_sample (in_sample),
		.in_busy   (in_busy),
		.out_valid (out_valid),
		.out_point (out_point),
		.out_pop   (out_pop)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// halve the interval once per rate bit from the msb and keep the low end
	function automatic sample_t bisect_point(input sample_t a, input sample_t b, input int rate);
		wide_sample_t lo;
		wide_sample_t hi;
		wide_sample_t mid;
		int           bit_i;
		lo = wide_sample_t'(a);
		hi = wide_sample_t'(b);
		for (bit_i = `UPS_RATE_BITS - 1; bit_i >= 0; bit_i--) begin
			mid = (lo + hi) >>> 1;
			if (rate[bit_i]) begin
				lo = mid;
			end else begin
				hi = mid;
			end
		end
		return sample_t'(lo[`UPS_SAMPLE_WIDTH-1:0]);
	endfunction

	task automatic check_value(input string name, input int got, input int expected);
		checks++;
		if (got != expected) begin
			errors++;
			$display("FAILED time=%0t signal=%s got=%0d expected=%0d",
				$time, name, got, expected);
		end
	endtask

	task automatic print_summary();
		$display("summary: checks=%0d errors=%0d samples=%0d points=%0d",
			checks, errors, accepted, popped);
	endtask

	task automatic abort_run(input string what);
		$display("timeout at %0t: %s", $time, what);
		print_summary();
		$display("Regression failed");
		$finish;
	endtask

	task automatic queue_segment(input sample_t cur);
		out_point_t pt;
		int         r;
		for (r = 0; r < SEG_POINTS; r++) begin
			pt.first  = (r == 0);
			pt.sample = bisect_point(prev_model, cur, r);
			exp_q.push_back(pt);
		end
		prev_model = cur;
		accepted++;
	endtask

	// strobe one sample and hold it until the producer takes it
	task automatic send_sample(input sample_t s, input int gap);
		int   waited;
		logic taken;
		repeat (gap) @(posedge clk);
		waited = 0;
		@(negedge clk);
		while (in_busy) begin
			waited++;
			if (waited > WAIT_LIMIT) abort_run("input stayed busy before a strobe");
			@(negedge clk);
		end
		@(posedge clk);
		in_valid  <= 1'b1;
		in_sample <= s;
		taken  = 1'b0;
		waited = 0;
		while (!taken) begin
			@(negedge clk);
			taken = !in_busy;
			waited++;
			if (waited > WAIT_LIMIT) abort_run("input strobe was never accepted");
			@(posedge clk);
		end
		in_valid <= 1'b0;
		queue_segment(s);
	endtask

	task automatic take_point();
		out_point_t exp_point;
		if (exp_q.size() == 0) begin
			errors++;
			$display("pop at %0t returned a point the model never produced", $time);
		end else begin
			exp_point = exp_q.pop_front();
			check_value("out_point.first", int'(out_point.first), int'(exp_point.first));
			check_value("out_point.sample", int'(out_point.sample), int'(exp_point.sample));
		end
		popped++;
	endtask

	task automatic drain_output();
		int waited;
		waited = 0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
			waited++;
			if (waited > WAIT_LIMIT) abort_run("expected points never came out");
		end
		repeat (3) @(negedge clk);
		check_value("out_valid", int'(out_valid), 0);
	endtask

	// ----------------------------------------------------------------------
	// consumer side
	// ----------------------------------------------------------------------

	initial begin : pop_side
		logic want;
		out_pop = 1'b0;
		forever begin
			@(posedge clk);
			pop_state = lcg_next(pop_state);
			case (pop_mode)
				POP_ALWAYS: want = 1'b1;
				POP_RANDOM: want = pop_state[28];
				default:    want = 1'b0;
			endcase
			out_pop <= want;
			// head is stable until the popping edge
			@(negedge clk);
			if (want && out_valid) take_point();
		end
	end

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------

	initial begin : main_flow
		sample_t s;
		int      gap;
		int      i;
		reset     = 1'b1;
		in_valid  = 1'b0;
		in_sample = '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		// quiet until the first strobe
		repeat (20) begin
			@(negedge clk);
			check_value("out_valid", int'(out_valid), 0);
			check_value("in_busy", int'(in_busy), 0);
		end

		// extremes and sign changes with the first segment starting at zero
		pop_mode = POP_ALWAYS;
		send_sample(sample_t'(127), 0);
		send_sample(sample_t'(-128), 0);
		send_sample(sample_t'(-128), 3);
		send_sample(sample_t'(127), 0);
		send_sample(sample_t'(-1), 1);
		send_sample(sample_t'(1), 0);
		drain_output();

		// without pops the FIFO fills and the producer has to stall
		pop_mode = POP_NONE;
		send_sample(sample_t'(-77), 0);
		repeat (100) @(negedge clk);
		repeat (40) begin
			@(negedge clk);
			check_value("in_busy", int'(in_busy), 1);
		end
		pop_mode = POP_RANDOM;
		send_sample(sample_t'(90), 0);
		drain_output();

		// random samples, gaps and pops
		for (i = 0; i < NUM_RANDOM; i++) begin
			stim_state = lcg_next(stim_state);
			case (stim_state[18:16])
				3'd0:    s = sample_t'(-128);
				3'd1:    s = sample_t'(127);
				default: s = sample_t'(stim_state[31:24]);
			endcase
			gap = int'(stim_state[21:20]);
			send_sample(s, gap);
		end
		drain_output();

		check_value("points popped", popped, accepted * SEG_POINTS);
		print_summary();
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
